//--- lsu_pkg.sv
// shared widths, operation codes and exception causes for the load/store unit
// memory word union with byte and halfword views
`default_nettype none

package lsu_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int unsigned XLEN       = 32;
    localparam int unsigned TRANS_ID_W = 3;
    localparam int unsigned OP_W       = 3;
    localparam int unsigned BE_W       = XLEN / 8;
    localparam int unsigned CAUSE_W    = 4;

    // local data RAM, 1 KiB of words
    localparam int unsigned RAM_WORDS = 256;
    localparam int unsigned RAM_AW    = 8;

    // --------------------
    // operation codes
    // --------------------
    // bit 2 marks a store, low bits give the size
    // low bits 11 are the unsigned loads, bit 2 selecting halfword
    localparam logic [OP_W-1:0] OP_LB  = 3'b000;
    localparam logic [OP_W-1:0] OP_LH  = 3'b001;
    localparam logic [OP_W-1:0] OP_LW  = 3'b010;
    localparam logic [OP_W-1:0] OP_LBU = 3'b011;
    localparam logic [OP_W-1:0] OP_SB  = 3'b100;
    localparam logic [OP_W-1:0] OP_SH  = 3'b101;
    localparam logic [OP_W-1:0] OP_SW  = 3'b110;
    localparam logic [OP_W-1:0] OP_LHU = 3'b111;

    // access sizes
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    // exception causes, as in the privileged spec
    localparam logic [CAUSE_W-1:0] CAUSE_LD_MISALIGNED   = 4'd4;
    localparam logic [CAUSE_W-1:0] CAUSE_LD_ACCESS_FAULT = 4'd5;
    localparam logic [CAUSE_W-1:0] CAUSE_ST_MISALIGNED   = 4'd6;
    localparam logic [CAUSE_W-1:0] CAUSE_ST_ACCESS_FAULT = 4'd7;

    // one RAM word, seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_t;

    // --------------------
    // op decode
    // --------------------
    function automatic logic op_is_store(logic [OP_W-1:0] op);
        return op[2] & (op[1:0] != 2'b11);
    endfunction

    function automatic logic op_is_unsigned(logic [OP_W-1:0] op);
        return op[1:0] == 2'b11;
    endfunction

    function automatic logic [1:0] op_size(logic [OP_W-1:0] op);
        return (op[1:0] == 2'b11) ? {1'b0, op[2]} : op[1:0];
    endfunction

endpackage

`default_nettype wire

//--- lsu_agu.sv
// address generation unit
// effective address, access size decode and byte enables
`timescale 1ns/10ps
`default_nettype none

module lsu_agu import lsu_pkg::*; (
    input  wire logic [OP_W-1:0] op_i,
    input  wire logic [XLEN-1:0] operand_a_i,
    input  wire logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0]      vaddr_o,
    output logic [BE_W-1:0]      be_o
);

    logic [1:0]        size;
    logic [BE_W-1:0]   size_mask;
    logic [2*BE_W-1:0] be_wide;

    // immediate arrives already sign extended
    assign vaddr_o = operand_a_i + imm_i;

    assign size = op_size(op_i);

    // --------------------
    // byte enables
    // --------------------
    always_comb begin
        unique case (size)
            SIZE_BYTE: size_mask = 4'b0001;
            SIZE_HALF: size_mask = 4'b0011;
            default:   size_mask = 4'b1111;
        endcase
    end

    // shift by the byte offset, lanes past the word are dropped
    assign be_wide = {{BE_W{1'b0}}, size_mask} << vaddr_o[1:0];
    assign be_o    = be_wide[BE_W-1:0];

endmodule

`default_nettype wire

//--- lsu_issue_reg.sv
// issue stage register holding the accepted request
// flush handling and load/store dispatch strobes
`timescale 1ns/10ps
`default_nettype none

module lsu_issue_reg import lsu_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  flush_i,
    input  wire logic                  valid_i,
    input  wire logic [OP_W-1:0]       op_i,
    input  wire logic [XLEN-1:0]       vaddr_i,
    input  wire logic [BE_W-1:0]       be_i,
    input  wire logic [XLEN-1:0]       wdata_i,
    input  wire logic [TRANS_ID_W-1:0] trans_id_i,
    output logic                       ld_valid_o,
    output logic                       st_valid_o,
    output logic [OP_W-1:0]            op_o,
    output logic [XLEN-1:0]            vaddr_o,
    output logic [BE_W-1:0]            be_o,
    output logic [XLEN-1:0]            wdata_o,
    output logic [TRANS_ID_W-1:0]      trans_id_o
);

    logic valid_q;

    // a flushed request is never accepted
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_o       <= op_i;
            vaddr_o    <= vaddr_i;
            be_o       <= be_i;
            wdata_o    <= wdata_i;
            trans_id_o <= trans_id_i;
        end
    end

    // --------------------
    // dispatch
    // --------------------
    // flush kills the held op before either unit samples it
    assign ld_valid_o = valid_q & ~flush_i & ~op_is_store(op_o);
    assign st_valid_o = valid_q & ~flush_i &  op_is_store(op_o);

endmodule

`default_nettype wire

//--- lsu_addr_check.sv
// misaligned access and access fault detection
// produces exception valid, cause and trap value
`timescale 1ns/10ps
`default_nettype none

module lsu_addr_check import lsu_pkg::*; (
    input  wire logic [OP_W-1:0] op_i,
    input  wire logic [XLEN-1:0] vaddr_i,
    output logic                 ex_valid_o,
    output logic [CAUSE_W-1:0]   ex_cause_o,
    output logic [XLEN-1:0]      ex_tval_o
);

    logic is_store;
    logic misaligned;
    logic fault;

    assign is_store = op_is_store(op_i);

    // byte accesses are always aligned
    always_comb begin
        unique case (op_size(op_i))
            SIZE_HALF: misaligned = vaddr_i[0];
            SIZE_WORD: misaligned = |vaddr_i[1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    // anything above the RAM is a fault
    assign fault = |vaddr_i[XLEN-1:RAM_AW+2];

    // access fault wins over misalignment
    always_comb begin
        ex_valid_o = fault | misaligned;
        ex_cause_o = '0;
        ex_tval_o  = '0;
        if (fault) begin
            ex_cause_o = is_store ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT;
            ex_tval_o  = vaddr_i;
        end else if (misaligned) begin
            ex_cause_o = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
            ex_tval_o  = vaddr_i;
        end
    end

endmodule

`default_nettype wire

//--- load_unit.sv
// load unit with RAM read request and result register
// lane extraction and sign or zero extension
`timescale 1ns/10ps
`default_nettype none

module load_unit import lsu_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  valid_i,
    input  wire logic [OP_W-1:0]       op_i,
    input  wire logic [XLEN-1:0]       vaddr_i,
    input  wire logic [TRANS_ID_W-1:0] trans_id_i,
    input  wire logic                  ex_valid_i,
    input  wire logic [CAUSE_W-1:0]    ex_cause_i,
    input  wire logic [XLEN-1:0]       ex_tval_i,
    input  wire mem_word_t             rdata_i,
    output logic [RAM_AW-1:0]          ram_index_o,
    output logic                       valid_o,
    output logic [TRANS_ID_W-1:0]      trans_id_o,
    output logic [XLEN-1:0]            result_o,
    output logic                       ex_valid_o,
    output logic [CAUSE_W-1:0]         ex_cause_o,
    output logic [XLEN-1:0]            ex_tval_o
);

    logic [OP_W-1:0] op_q;
    logic [1:0]      off_q;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic            sext;
    logic [XLEN-1:0] ld_data;

    // word index straight from the issue address
    assign ram_index_o = vaddr_i[RAM_AW+1:2];

    // --------------------
    // result register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o    <= 1'b0;
            ex_valid_o <= 1'b0;
        end else begin
            valid_o    <= valid_i;
            ex_valid_o <= valid_i & ex_valid_i;
        end
    end

    // sampled together with the RAM read
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_q       <= op_i;
            off_q      <= vaddr_i[1:0];
            trans_id_o <= trans_id_i;
            ex_cause_o <= ex_cause_i;
            ex_tval_o  <= ex_tval_i;
        end
    end

    // --------------------
    // lane extraction
    // --------------------
    assign ld_byte = rdata_i.b[off_q];
    assign ld_half = rdata_i.h[off_q[1]];
    assign sext    = ~op_is_unsigned(op_q);

    always_comb begin
        unique case (op_size(op_q))
            SIZE_BYTE: ld_data = {{(XLEN-8){sext & ld_byte[7]}}, ld_byte};
            SIZE_HALF: ld_data = {{(XLEN-16){sext & ld_half[15]}}, ld_half};
            default:   ld_data = rdata_i;
        endcase
    end

    // faulting loads return zero
    assign result_o = ex_valid_o ? '0 : ld_data;

endmodule

`default_nettype wire

//--- store_unit.sv
// store unit with data lane placement and RAM write strobe
// store completion register
`timescale 1ns/10ps
`default_nettype none

module store_unit import lsu_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  valid_i,
    input  wire logic [XLEN-1:0]       vaddr_i,
    input  wire logic [BE_W-1:0]       be_i,
    input  wire logic [XLEN-1:0]       wdata_i,
    input  wire logic [TRANS_ID_W-1:0] trans_id_i,
    input  wire logic                  ex_valid_i,
    input  wire logic [CAUSE_W-1:0]    ex_cause_i,
    input  wire logic [XLEN-1:0]       ex_tval_i,
    output logic                       ram_we_o,
    output logic [BE_W-1:0]            ram_be_o,
    output mem_word_t                  ram_wdata_o,
    output logic                       valid_o,
    output logic [TRANS_ID_W-1:0]      trans_id_o,
    output logic                       ex_valid_o,
    output logic [CAUSE_W-1:0]         ex_cause_o,
    output logic [XLEN-1:0]            ex_tval_o
);

    mem_word_t wdata_w;

    assign wdata_w = wdata_i;

    // rotate bytes up by the offset, enables pick the live lanes
    always_comb begin
        for (int i = 0; i < BE_W; i++) begin
            ram_wdata_o.b[i] = wdata_w.b[2'(i) - vaddr_i[1:0]];
        end
    end

    // no write for a faulting store
    assign ram_we_o = valid_i & ~ex_valid_i;
    assign ram_be_o = be_i;

    // --------------------
    // completion
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o    <= 1'b0;
            ex_valid_o <= 1'b0;
        end else begin
            valid_o    <= valid_i;
            ex_valid_o <= valid_i & ex_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            trans_id_o <= trans_id_i;
            ex_cause_o <= ex_cause_i;
            ex_tval_o  <= ex_tval_i;
        end
    end

endmodule

`default_nettype wire

//--- data_ram.sv
// single port data RAM
// byte enable writes, registered read
`timescale 1ns/10ps
`default_nettype none

module data_ram import lsu_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              we_i,
    input  wire logic [RAM_AW-1:0] index_i,
    input  wire logic [BE_W-1:0]   be_i,
    input  wire mem_word_t         wdata_i,
    output mem_word_t              rdata_o
);

    mem_word_t mem [RAM_WORDS];

    // per byte write
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < BE_W; i++) begin
                if (be_i[i]) begin
                    mem[index_i].b[i] <= wdata_i.b[i];
                end
            end
        end
    end

    // read data one cycle after the index
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[index_i];
    end

endmodule

`default_nettype wire

//--- load_store_unit.sv
// load/store unit top level
// AGU, issue register, address check, load and store units, data RAM
`timescale 1ns/10ps
`default_nettype none

module load_store_unit import lsu_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  flush_i,
    input  wire logic                  lsu_valid_i,
    input  wire logic [OP_W-1:0]       op_i,
    input  wire logic [XLEN-1:0]       operand_a_i,
    input  wire logic [XLEN-1:0]       imm_i,
    input  wire logic [XLEN-1:0]       wdata_i,
    input  wire logic [TRANS_ID_W-1:0] trans_id_i,
    output logic                       load_valid_o,
    output logic [TRANS_ID_W-1:0]      load_trans_id_o,
    output logic [XLEN-1:0]            load_result_o,
    output logic                       load_ex_valid_o,
    output logic [CAUSE_W-1:0]         load_ex_cause_o,
    output logic [XLEN-1:0]            load_ex_tval_o,
    output logic                       store_valid_o,
    output logic [TRANS_ID_W-1:0]      store_trans_id_o,
    output logic                       store_ex_valid_o,
    output logic [CAUSE_W-1:0]         store_ex_cause_o,
    output logic [XLEN-1:0]            store_ex_tval_o
);

    logic [XLEN-1:0]       agu_vaddr, iss_vaddr, iss_wdata, ex_tval;
    logic [BE_W-1:0]       agu_be, iss_be, ram_be;
    logic [OP_W-1:0]       iss_op;
    logic [TRANS_ID_W-1:0] iss_id;
    logic                  ld_valid, st_valid, ex_valid, ram_we;
    logic [CAUSE_W-1:0]    ex_cause;
    logic [RAM_AW-1:0]     ram_index;
    mem_word_t             ram_wdata, ram_rdata;

    lsu_agu i_agu (
        .op_i, .operand_a_i, .imm_i,
        .vaddr_o (agu_vaddr),
        .be_o    (agu_be)
    );

    lsu_issue_reg i_issue_reg (
        .clk_i, .rst_ni, .flush_i,
        .valid_i (lsu_valid_i), .op_i, .vaddr_i (agu_vaddr), .be_i (agu_be),
        .wdata_i, .trans_id_i,
        .ld_valid_o (ld_valid), .st_valid_o (st_valid), .op_o (iss_op),
        .vaddr_o (iss_vaddr), .be_o (iss_be), .wdata_o (iss_wdata), .trans_id_o (iss_id)
    );

    lsu_addr_check i_addr_check (
        .op_i (iss_op), .vaddr_i (iss_vaddr),
        .ex_valid_o (ex_valid), .ex_cause_o (ex_cause), .ex_tval_o (ex_tval)
    );

    // --------------------
    // load and store paths
    // --------------------
    // one op in the issue stage, so the load unit index serves stores too
    load_unit i_load_unit (
        .clk_i, .rst_ni,
        .valid_i (ld_valid), .op_i (iss_op), .vaddr_i (iss_vaddr), .trans_id_i (iss_id),
        .ex_valid_i (ex_valid), .ex_cause_i (ex_cause), .ex_tval_i (ex_tval),
        .rdata_i (ram_rdata), .ram_index_o (ram_index),
        .valid_o (load_valid_o), .trans_id_o (load_trans_id_o), .result_o (load_result_o),
        .ex_valid_o (load_ex_valid_o), .ex_cause_o (load_ex_cause_o),
        .ex_tval_o (load_ex_tval_o)
    );

    store_unit i_store_unit (
        .clk_i, .rst_ni,
        .valid_i (st_valid), .vaddr_i (iss_vaddr), .be_i (iss_be), .wdata_i (iss_wdata),
        .trans_id_i (iss_id),
        .ex_valid_i (ex_valid), .ex_cause_i (ex_cause), .ex_tval_i (ex_tval),
        .ram_we_o (ram_we), .ram_be_o (ram_be), .ram_wdata_o (ram_wdata),
        .valid_o (store_valid_o), .trans_id_o (store_trans_id_o),
        .ex_valid_o (store_ex_valid_o), .ex_cause_o (store_ex_cause_o),
        .ex_tval_o (store_ex_tval_o)
    );

    data_ram i_data_ram (
        .clk_i, .we_i (ram_we), .index_i (ram_index), .be_i (ram_be),
        .wdata_i (ram_wdata), .rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

//--- tb_load_store_unit.sv
// testbench for the load/store unit
// random requests with flush and exceptions checked against a memory and pipeline model
`timescale 1ns/10ps
`default_nettype none

module tb_load_store_unit import lsu_pkg::*; ();

    typedef struct packed {
        logic [31:0]           due;
        logic [TRANS_ID_W-1:0] id;
        logic [XLEN-1:0]       result;
        logic                  ex;
        logic [CAUSE_W-1:0]    cause;
        logic [XLEN-1:0]       tval;
    } expect_t;

    logic                  clk_i = 1'b0;
    logic                  rst_ni, flush_i, lsu_valid_i;
    logic [OP_W-1:0]       op_i;
    logic [XLEN-1:0]       operand_a_i, imm_i, wdata_i;
    logic [TRANS_ID_W-1:0] trans_id_i;
    logic                  load_valid_o, load_ex_valid_o, store_valid_o, store_ex_valid_o;
    logic [TRANS_ID_W-1:0] load_trans_id_o, store_trans_id_o;
    logic [XLEN-1:0]       load_result_o, load_ex_tval_o, store_ex_tval_o;
    logic [CAUSE_W-1:0]    load_ex_cause_o, store_ex_cause_o;

    // model state
    logic [XLEN-1:0]       mem_m [RAM_WORDS];
    expect_t               ld_q[$];
    expect_t               st_q[$];
    logic                  iss_v = 1'b0;
    logic [OP_W-1:0]       iss_op;
    logic [XLEN-1:0]       iss_addr, iss_wdata;
    logic [TRANS_ID_W-1:0] iss_id, next_id = '0;
    int                    cycle = 0, seed = 37591;
    int                    value_errors = 0, seq_errors = 0, n_loads = 0, n_stores = 0;
    logic                  timed_out = 1'b0;

    logic [OP_W-1:0] store_ops [4] = '{OP_SB, OP_SH, OP_SW, OP_SW};
    logic [OP_W-1:0] narrow_ops [4] = '{OP_LB, OP_LBU, OP_LH, OP_LHU};
    logic [OP_W-1:0] mis_ops [8] = '{OP_LH, OP_LHU, OP_LW, OP_SH, OP_SW, OP_LW, OP_SH, OP_SW};

    load_store_unit uut (.*);

    always #20 clk_i = ~clk_i;

    // --------------------
    // reference model
    // --------------------
    function automatic int access_bytes(input logic [OP_W-1:0] op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            default:              return 4;
        endcase
    endfunction

    function automatic logic is_store_op(input logic [OP_W-1:0] op);
        return op == OP_SB || op == OP_SH || op == OP_SW;
    endfunction

    // op leaving the issue stage at this edge
    task automatic retire_op();
        expect_t         e;
        int              nb;
        logic            st, fault, mis;
        logic [1:0]      off;
        logic [XLEN-1:0] word;
        nb    = access_bytes(iss_op);
        st    = is_store_op(iss_op);
        off   = iss_addr[1:0];
        fault = iss_addr >= 32'd1024;
        mis   = (nb == 2 && off[0]) || (nb == 4 && off != 2'b00);
        e      = '0;
        e.due  = cycle;
        e.id   = iss_id;
        e.ex   = fault || mis;
        e.tval = iss_addr;
        if (fault) begin
            e.cause = st ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT;
        end else if (mis) begin
            e.cause = st ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
        end
        word = mem_m[iss_addr[9:2]];
        if (st) begin
            for (int i = 0; i < nb && !e.ex; i++) begin
                word[8*(off+i) +: 8] = iss_wdata[8*i +: 8];
            end
            mem_m[iss_addr[9:2]] = word;
            st_q.push_back(e);
        end else begin
            word = word >> (8 * off);
            if (e.ex) begin
                e.result = '0;
            end else if (nb == 1) begin
                e.result = {{24{word[7] & (iss_op == OP_LB)}}, word[7:0]};
            end else if (nb == 2) begin
                e.result = {{16{word[15] & (iss_op == OP_LH)}}, word[15:0]};
            end else begin
                e.result = word;
            end
            ld_q.push_back(e);
        end
    endtask

    // advance the model by one edge and drive the next inputs
    task automatic step(input logic v, input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] imm, input logic [XLEN-1:0] wd, input logic fl);
        @(posedge clk_i);
        cycle++;
        if (iss_v && !flush_i) begin
            retire_op();
        end
        iss_v = lsu_valid_i && !flush_i;
        if (lsu_valid_i) begin
            iss_op    = op_i;
            iss_addr  = operand_a_i + imm_i;
            iss_wdata = wdata_i;
            iss_id    = trans_id_i;
        end
        lsu_valid_i <= v;
        op_i        <= op;
        operand_a_i <= a;
        imm_i       <= imm;
        wdata_i     <= wd;
        trans_id_i  <= next_id;
        flush_i     <= fl;
        if (v) begin
            next_id++;
        end
    endtask

    task automatic idle(input logic fl);
        step(1'b0, OP_LW, '0, '0, '0, fl);
    endtask

    // random sign extended 12 bit immediate with the base chosen to hit addr
    task automatic request(input logic [OP_W-1:0] op, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] wd, input logic fl);
        logic [XLEN-1:0] imm;
        imm = $random(seed);
        imm = {{20{imm[11]}}, imm[11:0]};
        step(1'b1, op, addr - imm, imm, wd, fl);
    endtask

    function automatic logic [XLEN-1:0] legal_addr(input logic [OP_W-1:0] op);
        logic [XLEN-1:0] r;
        r = $random(seed);
        return {22'h0, r[9:0]} & ~(access_bytes(op) - 1);
    endfunction

    function automatic logic [XLEN-1:0] misaligned_addr(input logic [OP_W-1:0] op);
        logic [XLEN-1:0] a;
        a = $random(seed);
        a = {22'h0, a[9:0]};
        if (access_bytes(op) == 2) begin
            a[0] = 1'b1;
        end else if (a[1:0] == 2'b00) begin
            a[1:0] = 2'b01;
        end
        return a;
    endfunction

    function automatic logic [XLEN-1:0] far_addr();
        logic [XLEN-1:0] a;
        a = $random(seed);
        a[10 + a[4:0] % 22] = 1'b1;
        return a;
    endfunction

    // --------------------
    // checks
    // --------------------
    task automatic value_error(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        value_errors++;
        $display("error: %s = 0x%0h, expected 0x%0h at cycle %0d", name, got, exp, cycle);
    endtask

    task automatic check_load(input logic [TRANS_ID_W-1:0] id, input logic [XLEN-1:0] result,
                              input logic ex, input logic [CAUSE_W-1:0] cause,
                              input logic [XLEN-1:0] tval, input expect_t e);
        if (id !== e.id)
            value_error("load_trans_id_o", id, e.id);
        if (result !== e.result)
            value_error("load_result_o", result, e.result);
        if (ex !== e.ex)
            value_error("load_ex_valid_o", ex, e.ex);
        if (e.ex && cause !== e.cause)
            value_error("load_ex_cause_o", cause, e.cause);
        if (e.ex && tval !== e.tval)
            value_error("load_ex_tval_o", tval, e.tval);
    endtask

    task automatic check_store(input logic [TRANS_ID_W-1:0] id, input logic ex,
                               input logic [CAUSE_W-1:0] cause, input logic [XLEN-1:0] tval,
                               input expect_t e);
        if (id !== e.id)
            value_error("store_trans_id_o", id, e.id);
        if (ex !== e.ex)
            value_error("store_ex_valid_o", ex, e.ex);
        if (e.ex && cause !== e.cause)
            value_error("store_ex_cause_o", cause, e.cause);
        if (e.ex && tval !== e.tval)
            value_error("store_ex_tval_o", tval, e.tval);
    endtask

    task automatic watch_loads();
        expect_t e;
        if (load_valid_o === 1'b1) begin
            if (ld_q.size() == 0) begin
                seq_errors++;
                $display("unexpected load result with id %0d at cycle %0d",
                         load_trans_id_o, cycle);
            end else begin
                e = ld_q.pop_front();
                n_loads++;
                if (e.due != cycle) begin
                    seq_errors++;
                    $display("load id %0d came at cycle %0d, not %0d", e.id, cycle, e.due);
                end
                check_load(load_trans_id_o, load_result_o, load_ex_valid_o, load_ex_cause_o,
                           load_ex_tval_o, e);
            end
        end else if (load_ex_valid_o !== 1'b0) begin
            seq_errors++;
            $display("load exception raised without a load result at cycle %0d", cycle);
        end else if (ld_q.size() != 0 && ld_q[0].due <= cycle) begin
            e = ld_q.pop_front();
            seq_errors++;
            $display("load id %0d due at cycle %0d never came", e.id, e.due);
        end
    endtask

    task automatic watch_stores();
        expect_t e;
        if (store_valid_o === 1'b1) begin
            if (st_q.size() == 0) begin
                seq_errors++;
                $display("unexpected store result with id %0d at cycle %0d",
                         store_trans_id_o, cycle);
            end else begin
                e = st_q.pop_front();
                n_stores++;
                if (e.due != cycle) begin
                    seq_errors++;
                    $display("store id %0d came at cycle %0d, not %0d", e.id, cycle, e.due);
                end
                check_store(store_trans_id_o, store_ex_valid_o, store_ex_cause_o,
                            store_ex_tval_o, e);
            end
        end else if (store_ex_valid_o !== 1'b0) begin
            seq_errors++;
            $display("store exception raised without a store result at cycle %0d", cycle);
        end else if (st_q.size() != 0 && st_q[0].due <= cycle) begin
            e = st_q.pop_front();
            seq_errors++;
            $display("store id %0d due at cycle %0d never came", e.id, e.due);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            if ({load_valid_o, store_valid_o, load_ex_valid_o, store_ex_valid_o} !== 4'b0) begin
                seq_errors++;
                $display("a valid output is high while reset is held");
            end
        end else begin
            watch_loads();
            watch_stores();
        end
    end

    task automatic drain();
        int waited;
        waited = 0;
        idle(1'b0);
        while (iss_v || ld_q.size() != 0 || st_q.size() != 0) begin
            if (waited == 20) begin
                $display("timeout: results still outstanding after %0d idle cycles", waited);
                timed_out = 1'b1;
                break;
            end
            idle(1'b0);
            waited++;
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin
        logic [31:0]     r;
        logic [XLEN-1:0] a;
        logic [OP_W-1:0] op;
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        lsu_valid_i = 1'b0;
        op_i        = OP_LW;
        operand_a_i = '0;
        imm_i       = '0;
        wdata_i     = '0;
        trans_id_i  = '0;
        repeat (16) idle(1'b0);
        rst_ni <= 1'b1;
        // quiet after reset
        repeat (8) idle(1'b0);

        // fill pattern from the whole word index
        for (int w = 0; w < RAM_WORDS; w++) begin
            request(OP_SW, w * 4, {8'(w), 8'(w) ^ 8'h5a, ~8'(w), 8'(w * 7 + 3)}, 1'b0);
        end
        // partial stores merged into the word
        for (int k = 0; k < 80; k++) begin
            r  = $random(seed);
            op = store_ops[r[1:0]];
            a  = legal_addr(op);
            request(op, a, $random(seed), 1'b0);
            request(OP_LW, a & 32'h3fc, '0, 1'b0);
        end
        for (int k = 0; k < 80; k++) begin
            r  = $random(seed);
            op = narrow_ops[r[1:0]];
            request(op, legal_addr(op), '0, 1'b0);
        end
        // misaligned access followed by a word load showing memory untouched
        for (int k = 0; k < 40; k++) begin
            r  = $random(seed);
            op = mis_ops[r[2:0]];
            a  = misaligned_addr(op);
            request(op, a, $random(seed), 1'b0);
            request(OP_LW, a & 32'h3fc, '0, 1'b0);
        end
        // out of range addresses whose index bits alias a real word
        for (int k = 0; k < 40; k++) begin
            r = $random(seed);
            a = far_addr();
            request(r[2:0], a, $random(seed), 1'b0);
            request(OP_LW, a & 32'h3fc, '0, 1'b0);
        end
        // back to back traffic with random flush
        for (int k = 0; k < 400; k++) begin
            r = $random(seed);
            a = (r[15:13] == 3'b000) ? far_addr() : {22'h0, r[31:22]};
            if (r[5:3] != 3'b000) begin
                request(r[2:0], a, $random(seed), r[9:6] == 4'h0);
            end else begin
                idle(r[9:6] == 4'h0);
            end
        end
        // final sweep catches stray or missing writes
        for (int w = 0; w < RAM_WORDS; w++) begin
            request(OP_LW, w * 4, '0, 1'b0);
        end
        drain();

        $display("errors: %0d value, %0d sequence, %0d timeout, over %0d loads and %0d stores",
                 value_errors, seq_errors, timed_out, n_loads, n_stores);
        if (value_errors == 0 && seq_errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
lsu_pkg.sv
lsu_agu.sv
lsu_issue_reg.sv
lsu_addr_check.sv
load_unit.sv
store_unit.sv
data_ram.sv
load_store_unit.sv
tb_load_store_unit.sv
